/* files.f */
+incdir+verif
logic/pcs_pkg.sv
logic/block_classifier.sv
logic/tx_sequence_checker.sv
logic/tx_block_output.sv
logic/pcs_tx_encoder.sv
verif/pcs_tx_tb.sv

/* logic/block_classifier.sv */
// Decode stage: registers the CGMII word, classifies it and builds the 66-bit block
module block_classifier
(
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_valid,
	input  pcs_pkg::mii_data_t i_tx_data,
	input  pcs_pkg::mii_ctrl_t i_tx_ctrl,
	output logic               o_valid,
	output pcs_pkg::block_t    o_block,
	output pcs_pkg::t_type_t   o_type
);
	import pcs_pkg::*;

	mii_data_t  tx_data;
	mii_ctrl_t  tx_ctrl;
	logic [7:0] char_ok;
	logic [6:0] pcs_char [8];
	logic [7:0] term_hit;
	logic [2:0] term_pos;
	logic       is_data;
	logic       is_ord_mask;
	logic       is_start;
	logic       is_q;
	logic       is_fsig;
	logic       is_idle;
	logic [3:0] ord_code;

	// Returns {valid, pcs character}; only idle and error have a PCS code
	function automatic logic [7:0] map_char(input logic [7:0] c);
		case (c)
			CGMII_IDLE:  return {1'b1, PCS_IDLE};
			CGMII_ERROR: return {1'b1, PCS_ERROR};
			default:     return 8'h00;
		endcase
	endfunction

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	// Word register, loaded only on valid input
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			tx_data <= i_tx_data;
			tx_ctrl <= i_tx_ctrl;
		end
	end

	// Per-byte character mapping, index i is byte i
	always_comb
	begin
		for (int i = 0; i < 8; i++)
			{char_ok[i], pcs_char[i]} = map_char(tx_data[63 - 8*i -: 8]);
	end

	assign is_data     = (tx_ctrl == 8'h00);
	assign is_ord_mask = (tx_ctrl == 8'h80);
	assign is_start    = is_ord_mask && (tx_data[63 -: 8] == CGMII_START);
	assign is_q        = is_ord_mask && (tx_data[63 -: 8] == CGMII_Q);
	assign is_fsig     = is_ord_mask && (tx_data[63 -: 8] == CGMII_FSIG);
	assign is_idle     = (tx_ctrl == 8'hFF) && (tx_data == {8{CGMII_IDLE}});
	assign ord_code    = is_q ? PCS_Q : PCS_FSIG;

	// Terminate in byte n: control on bytes n..7, every byte after T idle or error
	always_comb
	begin
		logic fill_ok;

		term_hit = '0;
		term_pos = '0;
		for (int n = 0; n < 8; n++)
		begin
			fill_ok = 1'b1;
			for (int k = n + 1; k < 8; k++)
				fill_ok = fill_ok & char_ok[k];
			term_hit[n] = (tx_ctrl == (8'hFF >> n)) &&
				(tx_data[63 - 8*n -: 8] == CGMII_TERMINATE) && fill_ok;
			if (term_hit[n])
				term_pos = 3'(n);
		end
	end

	always_comb
	begin
		o_block = EBLOCK_T;
		o_type  = T_TYPE_E;
		if (is_data)
		begin
			o_block = {DATA_SH, tx_data};
			o_type  = T_TYPE_D;
		end
		else if (is_start)
		begin
			o_block = {CTRL_SH, BTYPE_S, tx_data[55:0]};
			o_type  = T_TYPE_S;
		end
		else if (is_q || is_fsig)
		begin
			o_block = {CTRL_SH, BTYPE_ORDER, tx_data[55 -: 24], ord_code, 28'h0};
			o_type  = T_TYPE_C;
		end
		else if (is_idle)
		begin
			o_block = {CTRL_SH, BTYPE_CTRL, {8{PCS_IDLE}}};
			o_type  = T_TYPE_C;
		end
		else if (|term_hit)
		begin
			o_type = T_TYPE_T;
			// Data bytes before T, zero fill, then mapped characters after T
			case (term_pos)
				3'd0: o_block = {CTRL_SH, BTYPE_T0, 7'h0, pcs_char[1], pcs_char[2],
					pcs_char[3], pcs_char[4], pcs_char[5], pcs_char[6], pcs_char[7]};
				3'd1: o_block = {CTRL_SH, BTYPE_T1, tx_data[63 -: 8], 6'h0, pcs_char[2],
					pcs_char[3], pcs_char[4], pcs_char[5], pcs_char[6], pcs_char[7]};
				3'd2: o_block = {CTRL_SH, BTYPE_T2, tx_data[63 -: 16], 5'h0,
					pcs_char[3], pcs_char[4], pcs_char[5], pcs_char[6], pcs_char[7]};
				3'd3: o_block = {CTRL_SH, BTYPE_T3, tx_data[63 -: 24], 4'h0,
					pcs_char[4], pcs_char[5], pcs_char[6], pcs_char[7]};
				3'd4: o_block = {CTRL_SH, BTYPE_T4, tx_data[63 -: 32], 3'h0,
					pcs_char[5], pcs_char[6], pcs_char[7]};
				3'd5: o_block = {CTRL_SH, BTYPE_T5, tx_data[63 -: 40], 2'h0,
					pcs_char[6], pcs_char[7]};
				3'd6: o_block = {CTRL_SH, BTYPE_T6, tx_data[63 -: 48], 1'b0, pcs_char[7]};
				default: o_block = {CTRL_SH, BTYPE_T7, tx_data[63 -: 56]};
			endcase
		end
	end

endmodule

/* logic/pcs_pkg.sv */
// Shared widths, character codes and block constants of the 100GBASE-R transmit PCS
package pcs_pkg;

	// One CGMII word, byte 0 in the top bits
	typedef logic [63:0] mii_data_t;
	// Control bits, bit 7 belongs to byte 0
	typedef logic [7:0]  mii_ctrl_t;
	// 66-bit block, sync header in bits 65:64
	typedef logic [65:0] block_t;
	typedef logic [1:0]  sync_header_t;
	// One-hot block kind {D, S, C, T}, zero is E
	typedef logic [3:0]  t_type_t;
	typedef logic [57:0] scr_state_t;

	localparam t_type_t T_TYPE_D = 4'b1000;
	localparam t_type_t T_TYPE_S = 4'b0100;
	localparam t_type_t T_TYPE_C = 4'b0010;
	localparam t_type_t T_TYPE_T = 4'b0001;
	localparam t_type_t T_TYPE_E = 4'b0000;

	// CGMII control characters
	localparam logic [7:0] CGMII_START     = 8'hFB;
	localparam logic [7:0] CGMII_TERMINATE = 8'hFD;
	localparam logic [7:0] CGMII_FSIG      = 8'h5C;
	localparam logic [7:0] CGMII_Q         = 8'h9C;
	localparam logic [7:0] CGMII_IDLE      = 8'h07;
	localparam logic [7:0] CGMII_ERROR     = 8'hFE;

	// PCS control characters and ordered-set codes
	localparam logic [6:0] PCS_IDLE  = 7'h00;
	localparam logic [6:0] PCS_ERROR = 7'h1E;
	localparam logic [3:0] PCS_Q     = 4'h0;
	localparam logic [3:0] PCS_FSIG  = 4'hF;

	localparam sync_header_t DATA_SH = 2'b01;
	localparam sync_header_t CTRL_SH = 2'b10;

	// Block type field values
	localparam logic [7:0] BTYPE_CTRL  = 8'h1E;
	localparam logic [7:0] BTYPE_S     = 8'h78;
	localparam logic [7:0] BTYPE_ORDER = 8'h4B;
	localparam logic [7:0] BTYPE_T0    = 8'h87;
	localparam logic [7:0] BTYPE_T1    = 8'h99;
	localparam logic [7:0] BTYPE_T2    = 8'hAA;
	localparam logic [7:0] BTYPE_T3    = 8'hB4;
	localparam logic [7:0] BTYPE_T4    = 8'hCC;
	localparam logic [7:0] BTYPE_T5    = 8'hD2;
	localparam logic [7:0] BTYPE_T6    = 8'hE1;
	localparam logic [7:0] BTYPE_T7    = 8'hFF;

	// Control block filled with error characters
	localparam block_t EBLOCK_T = {CTRL_SH, BTYPE_CTRL, {8{PCS_ERROR}}};

	// Scrambler state after reset
	localparam scr_state_t SCRAMBLER_SEED = '1;

endpackage

/* logic/pcs_tx_encoder.sv */
// 100GBASE-R transmit encoder: classify, sequence check, then scramble and deliver
module pcs_tx_encoder
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_valid,
	input  pcs_pkg::mii_data_t i_tx_data,
	input  pcs_pkg::mii_ctrl_t i_tx_ctrl,
	input  logic               i_out_credit,
	output logic               o_valid,
	output pcs_pkg::block_t    o_block,
	output logic               o_in_credit
);
	import pcs_pkg::*;

	logic    dec_valid;
	block_t  dec_block;
	t_type_t dec_type;
	logic    exe_valid;
	block_t  exe_block;

	block_classifier block_classifier_inst
	(
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_valid   (i_valid),
		.i_tx_data (i_tx_data),
		.i_tx_ctrl (i_tx_ctrl),
		.o_valid   (dec_valid),
		.o_block   (dec_block),
		.o_type    (dec_type)
	);

	tx_sequence_checker tx_sequence_checker_inst
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_valid (dec_valid),
		.i_block (dec_block),
		.i_type  (dec_type),
		.o_valid (exe_valid),
		.o_block (exe_block)
	);

	tx_block_output #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) tx_block_output_inst
	(
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_valid      (exe_valid),
		.i_block      (exe_block),
		.i_out_credit (i_out_credit),
		.o_valid      (o_valid),
		.o_block      (o_block),
		.o_in_credit  (o_in_credit)
	);

endmodule

/* logic/tx_block_output.sv */
// Result stage: block FIFO, payload scrambler and credit flow control on both sides
module tx_block_output
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  logic            i_clock,
	input  logic            i_reset,
	input  logic            i_valid,
	input  pcs_pkg::block_t i_block,
	input  logic            i_out_credit,
	output logic            o_valid,
	output pcs_pkg::block_t o_block,
	output logic            o_in_credit
);
	import pcs_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	block_t           mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic [CNT_W-1:0] credits;
	logic             pop;
	block_t           head;
	scr_state_t       scr_state;
	scr_state_t       scr_next;
	mii_data_t        scr_payload;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// Pop needs a stored block and a sink credit
	assign pop  = (fill != '0) && (credits != '0);
	assign head = mem[rd_ptr];

	always_ff @(posedge i_clock)
	begin
		if (i_valid)
			mem[wr_ptr] <= i_block;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			fill    <= '0;
			credits <= '0;
		end
		else
		begin
			if (i_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (i_valid && !pop)
				fill <= fill + 1'b1;
			else if (pop && !i_valid)
				fill <= fill - 1'b1;
			// Sink keeps at most FIFO_DEPTH grants outstanding
			if (i_out_credit && !pop)
				credits <= credits + 1'b1;
			else if (pop && !i_out_credit)
				credits <= credits - 1'b1;
		end
	end

	// Self-synchronizing x^58 + x^39 + 1, payload bit 0 first
	always_comb
	begin
		scr_next = scr_state;
		for (int i = 0; i < 64; i++)
		begin
			scr_payload[i] = head[i] ^ scr_next[38] ^ scr_next[57];
			scr_next = {scr_next[56:0], scr_payload[i]};
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			scr_state <= SCRAMBLER_SEED;
			o_valid   <= 1'b0;
		end
		else
		begin
			o_valid <= pop;
			if (pop)
				scr_state <= scr_next;
		end
	end

	// Sync header is sent in the clear
	always_ff @(posedge i_clock)
	begin
		if (pop)
			o_block <= {head[65:64], scr_payload};
	end

	// Each block sent frees one FIFO slot for the source
	assign o_in_credit = o_valid;

endmodule

/* logic/tx_sequence_checker.sv */
// Execute stage: transmit sequence FSM that replaces illegal blocks with error blocks
module tx_sequence_checker
(
	input  logic             i_clock,
	input  logic             i_reset,
	input  logic             i_valid,
	input  pcs_pkg::block_t  i_block,
	input  pcs_pkg::t_type_t i_type,
	output logic             o_valid,
	output pcs_pkg::block_t  o_block
);
	import pcs_pkg::*;

	typedef enum logic [2:0]
	{
		TX_INIT,
		TX_C,
		TX_D,
		TX_T,
		TX_E
	} tx_state_t;

	tx_state_t state;
	tx_state_t state_next;

	// Anything not listed for a state falls to TX_E
	always_comb
	begin
		state_next = TX_E;
		case (state)
			TX_INIT, TX_C, TX_T:
			begin
				if (i_type == T_TYPE_C)
					state_next = TX_C;
				else if (i_type == T_TYPE_S)
					state_next = TX_D;
			end
			TX_D:
			begin
				if (i_type == T_TYPE_D)
					state_next = TX_D;
				else if (i_type == T_TYPE_T)
					state_next = TX_T;
			end
			TX_E:
			begin
				if (i_type == T_TYPE_D)
					state_next = TX_D;
				else if (i_type == T_TYPE_T)
					state_next = TX_T;
				else if (i_type == T_TYPE_C)
					state_next = TX_C;
			end
			default:
				state_next = TX_E;
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state   <= TX_INIT;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_valid;
			if (i_valid)
				state <= state_next;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_valid)
			o_block <= (state_next == TX_E) ? EBLOCK_T : i_block;
	end

endmodule

/* verif/pcs_tx_model.svh */
// Reference model of the transmit encoder: classify, sequence FSM, scrambler and LFSR
`ifndef PCS_TX_MODEL_SVH
`define PCS_TX_MODEL_SVH

// Model FSM states
localparam int M_INIT = 0;
localparam int M_C    = 1;
localparam int M_D    = 2;
localparam int M_T    = 3;
localparam int M_E    = 4;

// Terminate type codes, T0 in the top byte
localparam logic [63:0] T_CODE_LIST = {BTYPE_T0, BTYPE_T1, BTYPE_T2, BTYPE_T3,
	BTYPE_T4, BTYPE_T5, BTYPE_T6, BTYPE_T7};

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Fill character after T, returns {legal, 7-bit PCS code}
function automatic logic [7:0] fill_code(input logic [7:0] c);
	if (c == CGMII_IDLE)
		return {1'b1, PCS_IDLE};
	if (c == CGMII_ERROR)
		return {1'b1, PCS_ERROR};
	return 8'h00;
endfunction

// Returns {block kind, 66-bit block} for one CGMII word
function automatic logic [69:0] classify_word(input mii_data_t d, input mii_ctrl_t c);
	logic [55:0] body;
	logic [7:0]  m;
	logic        fill_ok;

	if (c == 8'h00)
		return {T_TYPE_D, DATA_SH, d};
	if (c == 8'h80 && d[63:56] == CGMII_START)
		return {T_TYPE_S, CTRL_SH, BTYPE_S, d[55:0]};
	if (c == 8'h80 && d[63:56] == CGMII_Q)
		return {T_TYPE_C, CTRL_SH, BTYPE_ORDER, d[55:32], PCS_Q, 28'h0};
	if (c == 8'h80 && d[63:56] == CGMII_FSIG)
		return {T_TYPE_C, CTRL_SH, BTYPE_ORDER, d[55:32], PCS_FSIG, 28'h0};
	if (c == 8'hFF && d == {8{CGMII_IDLE}})
		return {T_TYPE_C, CTRL_SH, BTYPE_CTRL, {8{PCS_IDLE}}};
	for (int n = 0; n < 8; n++)
	begin
		if (c == (8'hFF >> n) && d[63 - 8*n -: 8] == CGMII_TERMINATE)
		begin
			fill_ok = 1'b1;
			body = '0;
			for (int i = 0; i < n; i++)
				body = {body[47:0], d[63 - 8*i -: 8]};
			// 7 - n zero bits between data and fill
			body = body << (7 - n);
			for (int k = n + 1; k < 8; k++)
			begin
				m = fill_code(d[63 - 8*k -: 8]);
				fill_ok = fill_ok & m[7];
				body = {body[48:0], m[6:0]};
			end
			if (fill_ok)
				return {T_TYPE_T, CTRL_SH, T_CODE_LIST[63 - 8*n -: 8], body};
		end
	end
	return {T_TYPE_E, EBLOCK_T};
endfunction

// Transmit sequence rule
function automatic int seq_next(input int st, input t_type_t kind);
	case (st)
		M_D:
		begin
			if (kind == T_TYPE_D)
				return M_D;
			if (kind == T_TYPE_T)
				return M_T;
		end
		M_E:
		begin
			if (kind == T_TYPE_D)
				return M_D;
			if (kind == T_TYPE_T)
				return M_T;
			if (kind == T_TYPE_C)
				return M_C;
		end
		default:
		begin
			if (kind == T_TYPE_C)
				return M_C;
			if (kind == T_TYPE_S)
				return M_D;
		end
	endcase
	return M_E;
endfunction

// x^58 + x^39 + 1, bit 0 first, returns {new state, scrambled payload}
function automatic logic [121:0] scramble_payload(input scr_state_t st, input mii_data_t p);
	scr_state_t s;
	mii_data_t  o;

	s = st;
	for (int i = 0; i < 64; i++)
	begin
		o[i] = p[i] ^ s[38] ^ s[57];
		s = {s[56:0], o[i]};
	end
	return {s, o};
endfunction

`endif

/* verif/pcs_tx_tb.sv */
// Testbench checking the transmit encoder against a reference model on a random CGMII stream
module pcs_tx_tb;
	import pcs_pkg::*;
	`include "pcs_tx_model.svh"

	localparam int FIFO_DEPTH  = 8;
	localparam int UNITS       = 300;
	localparam int STALL_LIMIT = 300;

	logic      i_clock;
	logic      i_reset;
	logic      i_valid;
	mii_data_t i_tx_data;
	mii_ctrl_t i_tx_ctrl;
	logic      i_out_credit;
	logic      o_valid;
	block_t    o_block;
	logic      o_in_credit;

	mii_data_t  stim_data [$];
	mii_ctrl_t  stim_ctrl [$];
	block_t     exp_q [$];
	logic [31:0] lfsr_state;
	int         model_state;
	scr_state_t model_scr;
	int         src_credits;
	int         granted;
	int         received;
	int         in_credits;
	int         burst_left;
	int         pause_left;
	int         header_errors;
	int         payload_errors;
	int         flow_errors;
	bit         timed_out;

	pcs_tx_encoder #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) pcs_tx_encoder_inst
	(
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_valid      (i_valid),
		.i_tx_data    (i_tx_data),
		.i_tx_ctrl    (i_tx_ctrl),
		.i_out_credit (i_out_credit),
		.o_valid      (o_valid),
		.o_block      (o_block),
		.o_in_credit  (o_in_credit)
	);

	always #10 i_clock = ~i_clock;

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;

		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic push_word(input mii_data_t d, input mii_ctrl_t c);
		stim_data.push_back(d);
		stim_ctrl.push_back(c);
	endtask

	task automatic start_word();
		logic [31:0] hi;
		logic [31:0] lo;

		hi = rand_bits(24);
		lo = rand_bits(32);
		push_word({CGMII_START, hi[23:0], lo}, 8'h80);
	endtask

	task automatic data_word();
		logic [31:0] hi;
		logic [31:0] lo;

		hi = rand_bits(32);
		lo = rand_bits(32);
		push_word({hi, lo}, 8'h00);
	endtask

	// Terminate word with idle or error fill and an optional bad last byte
	task automatic term_word(input int pos, input bit bad_fill);
		mii_data_t   d;
		logic [31:0] hi;
		logic [31:0] lo;

		hi = rand_bits(32);
		lo = rand_bits(32);
		d = {hi, lo};
		d[63 - 8*pos -: 8] = CGMII_TERMINATE;
		for (int k = pos + 1; k < 8; k++)
			d[63 - 8*k -: 8] = rand_bits(1) ? CGMII_ERROR : CGMII_IDLE;
		if (bad_fill)
			d[7:0] = 8'h55;
		push_word(d, 8'hFF >> pos);
	endtask

	task automatic add_frame(input int pos, input bit bad_fill);
		int nd;

		nd = rand_bits(2);
		start_word();
		for (int i = 0; i < nd; i++)
			data_word();
		term_word(pos, bad_fill);
	endtask

	task automatic build_stream();
		logic [31:0] sel;
		logic [31:0] hi;
		logic [31:0] lo;
		int          pos;

		// Every terminate position once up front
		for (int i = 0; i < 8; i++)
			add_frame(i, 1'b0);
		for (int u = 0; u < UNITS; u++)
		begin
			sel = rand_bits(4);
			hi = rand_bits(32);
			lo = rand_bits(32);
			case (sel)
				7, 8: push_word({8{CGMII_IDLE}}, 8'hFF);
				9: push_word({CGMII_Q, hi[23:0], lo}, 8'h80);
				10: push_word({CGMII_FSIG, hi[23:0], lo}, 8'h80);
				// Data without a start
				11: data_word();
				// Start after start
				12:
				begin
					start_word();
					add_frame(rand_bits(3), 1'b0);
				end
				// Control block inside a frame and the recovery after it
				13:
				begin
					start_word();
					push_word({8{CGMII_IDLE}}, 8'hFF);
					data_word();
					term_word(rand_bits(3), 1'b0);
				end
				14:
				begin
					if (rand_bits(1))
						push_word({8'h1C, {7{CGMII_IDLE}}}, 8'hFF);
					else
						push_word({hi, lo}, 8'h3C);
				end
				15:
				begin
					pos = rand_bits(3);
					add_frame((pos == 7) ? 6 : pos, 1'b1);
				end
				default: add_frame(rand_bits(3), 1'b0);
			endcase
		end
	endtask

	task automatic check_header(input string name, input sync_header_t exp,
		input sync_header_t act);
		if (exp !== act)
		begin
			header_errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_payload(input string name, input mii_data_t exp,
		input mii_data_t act);
		if (exp !== act)
		begin
			payload_errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic watch_output();
		block_t exp;

		if (o_in_credit === 1'b1)
			in_credits++;
		if (o_valid === 1'b1)
		begin
			received++;
			if (received > granted)
			begin
				flow_errors++;
				$display("Block %0d was sent without a sink credit", received);
			end
			if (exp_q.size() == 0)
			begin
				flow_errors++;
				$display("Block %0d arrived when no block was expected", received);
			end
			else
			begin
				exp = exp_q.pop_front();
				check_header($sformatf("block %0d sync header", received), exp[65:64],
					o_block[65:64]);
				check_payload($sformatf("block %0d payload", received), exp[63:0],
					o_block[63:0]);
			end
		end
	endtask

	// Source sends while credits remain and runs each word through the model
	task automatic drive_source();
		logic [69:0]  cls;
		logic [121:0] scr;
		block_t       blk;

		if (o_in_credit === 1'b1)
			src_credits++;
		i_valid = 1'b0;
		if (src_credits > 0 && stim_data.size() > 0 && rand_bits(2) != 0)
		begin
			i_tx_data = stim_data.pop_front();
			i_tx_ctrl = stim_ctrl.pop_front();
			i_valid = 1'b1;
			src_credits--;
			cls = classify_word(i_tx_data, i_tx_ctrl);
			model_state = seq_next(model_state, cls[69:66]);
			blk = (model_state == M_E) ? EBLOCK_T : cls[65:0];
			scr = scramble_payload(model_scr, blk[63:0]);
			model_scr = scr[121:64];
			exp_q.push_back({blk[65:64], scr[63:0]});
		end
	endtask

	// Sink grants in random bursts and pauses with at most FIFO_DEPTH outstanding
	task automatic drive_sink();
		i_out_credit = 1'b0;
		if (burst_left > 0)
		begin
			if (granted - received < FIFO_DEPTH)
			begin
				i_out_credit = 1'b1;
				granted++;
				burst_left--;
			end
		end
		else if (pause_left > 0)
			pause_left--;
		else
		begin
			burst_left = 1 + rand_bits(2);
			pause_left = rand_bits(3);
		end
	endtask

	task automatic step_cycle();
		@(negedge i_clock);
		watch_output();
		drive_source();
		drive_sink();
	endtask

	initial
	begin
		int stall;
		int marker;

		i_clock = 1'b0;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_tx_data = '0;
		i_tx_ctrl = '0;
		i_out_credit = 1'b0;
		lfsr_state = 32'h9ab5_c21d;
		model_state = M_INIT;
		model_scr = SCRAMBLER_SEED;
		src_credits = 0;
		granted = 0;
		received = 0;
		in_credits = 0;
		burst_left = 0;
		pause_left = 0;
		header_errors = 0;
		payload_errors = 0;
		flow_errors = 0;
		timed_out = 1'b0;
		build_stream();

		repeat (4) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		src_credits = FIFO_DEPTH;

		// Send phase
		stall = 0;
		while (stim_data.size() > 0 && !timed_out)
		begin
			marker = stim_data.size();
			step_cycle();
			stall = (marker == stim_data.size()) ? stall + 1 : 0;
			if (stall > STALL_LIMIT)
			begin
				timed_out = 1'b1;
				$display("Timeout: blocks stopped arriving while words were still queued");
			end
		end

		// Drain phase
		stall = 0;
		while (exp_q.size() > 0 && !timed_out)
		begin
			marker = received;
			step_cycle();
			stall = (marker == received) ? stall + 1 : 0;
			if (stall > STALL_LIMIT)
			begin
				timed_out = 1'b1;
				$display("Timeout: blocks stopped arriving, %0d still expected", exp_q.size());
			end
		end

		if (!timed_out)
		begin
			// A few spare cycles catch any extra block
			repeat (10) step_cycle();
			if (in_credits != received)
			begin
				flow_errors++;
				$display("Input credits returned %0d times for %0d blocks", in_credits,
					received);
			end
		end

		$display("Blocks %0d, header errors %0d, payload errors %0d, flow errors %0d, timeouts %0d",
			received, header_errors, payload_errors, flow_errors, timed_out);
		if (header_errors == 0 && payload_errors == 0 && flow_errors == 0 && !timed_out)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
